/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_eg
FLIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* source/eg_defs.svh */
`default_nettype none

`ifndef EG_DEFS_SVH
`define EG_DEFS_SVH

// attenuation level width and the fully silent level.
`define EG_LEVEL_W 10
`define EG_LEVEL_MAX 10'd1023

// effective rate width and envelope counter width.
`define EG_RATE_W 6
`define EG_CNT_W 12

// clocks per sample and samples per envelope tick.
`define EG_SAMPLE_DIV 4
`define EG_SUBCNT_DIV 3

// effective rate thresholds.
`define EG_INSTANT_RATE 6'd62
`define EG_FAST_RATE 6'd48

// register map.
`define EG_ADDR_AR 3'd0
`define EG_ADDR_DR 3'd1
`define EG_ADDR_SR 3'd2
`define EG_ADDR_RR 3'd3
`define EG_ADDR_SL 3'd4
`define EG_ADDR_TL 3'd5
`define EG_ADDR_KSAM 3'd6
`define EG_ADDR_KC 3'd7

`endif

`default_nettype wire

/* source/eg_envelope.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module eg_envelope import eg_pkg::*;
	(
	input  logic mclk_i,
	input  logic rst_n_i,
	input  logic eg_tick_i,
	input  logic kon_i,
	input  logic step_i,
	input  eg_inc_t inc_i,
	input  eg_rate_t eff_rate_i,
	input  logic [3:0] sl_i,
	output eg_state_t state_o,
	output eg_level_t level_o
	);

	eg_state_t state_q;
	eg_state_t state_d;
	eg_level_t level_q;
	eg_level_t level_d;
	logic kon_q;
	logic kon_rise;
	logic [4:0] sl_level;
	logic sl_reach;
	logic quiet;
	logic [13:0] att_prod;
	logic [10:0] att_dec;
	eg_level_t att_next;
	logic [10:0] lin_sum;
	eg_level_t lin_next;

	assign kon_rise = kon_i && !kon_q;

	// a sustain level of 15 means the bottom of the range.
	assign sl_level = (sl_i == 4'hf) ? 5'h1f : {1'b0, sl_i};
	assign sl_reach = (level_q[9:5] == sl_level);
	assign quiet = (level_q[9:4] == 6'h3f);

	// exponential attack: the step shrinks as the level approaches zero.
	assign att_prod = level_q * inc_i;
	assign att_dec = {1'b0, att_prod[13:4]} + 11'd1;

	always_comb
	begin
		if (!step_i)
			att_next = level_q;
		else if (att_dec >= {1'b0, level_q})
			att_next = '0;
		else
			att_next = level_q - att_dec[9:0];
	end

	assign lin_sum = {1'b0, level_q} + inc_i;
	assign lin_next = lin_sum[10] ? `EG_LEVEL_MAX : lin_sum[9:0];

	always_comb
	begin
		state_d = state_q;
		level_d = level_q;
		if (kon_rise)
		begin
			state_d = EG_ATTACK;
			if (eff_rate_i >= `EG_INSTANT_RATE)
				level_d = '0;
		end
		else if (!kon_i && state_q != EG_RELEASE)
			state_d = EG_RELEASE;
		else if (state_q == EG_ATTACK)
		begin
			level_d = att_next;
			if (att_next == '0)
				state_d = EG_DECAY;
		end
		else if (quiet)
			level_d = `EG_LEVEL_MAX;
		else if (state_q == EG_DECAY && sl_reach)
			state_d = EG_SUSTAIN;
		else if (step_i)
			level_d = lin_next;
	end

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			kon_q <= 1'b0;
			state_q <= EG_RELEASE;
			level_q <= `EG_LEVEL_MAX;
		end
		else if (eg_tick_i)
		begin
			kon_q <= kon_i;
			state_q <= state_d;
			level_q <= level_d;
		end
	end

	// a pending key-on asks for the attack rate so the instant check sees it.
	assign state_o = kon_rise ? EG_ATTACK : state_q;
	assign level_o = level_q;

endmodule

`default_nettype wire

/* source/eg_output.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module eg_output import eg_pkg::*;
	(
	input  logic mclk_i,
	input  logic rst_n_i,
	input  eg_level_t level_i,
	input  logic [6:0] tl_i,
	input  logic [1:0] ams_i,
	input  logic [5:0] lfo_am_i,
	output eg_level_t eg_out_o
	);

	logic [6:0] am_val;
	logic [11:0] sum;

	always_comb
	begin
		case (ams_i)
			2'd0: am_val = '0;
			2'd1: am_val = {3'b000, lfo_am_i[5:2]};
			2'd2: am_val = {1'b0, lfo_am_i};
			default: am_val = {lfo_am_i, 1'b0};
		endcase
	end

	// total level counts in steps of eight attenuation units.
	assign sum = level_i + {tl_i, 3'b000} + am_val;

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			eg_out_o <= `EG_LEVEL_MAX;
		else if (sum[11:10] != 2'b00)
			eg_out_o <= `EG_LEVEL_MAX;
		else
			eg_out_o <= sum[9:0];
	end

endmodule

`default_nettype wire

/* source/eg_pkg.sv */
`include "eg_defs.svh"

`default_nettype none

package eg_pkg;

	// envelope phases, in the same order as the rate registers.
	typedef enum logic [1:0]
	{
		EG_ATTACK = 2'd0,
		EG_DECAY = 2'd1,
		EG_SUSTAIN = 2'd2,
		EG_RELEASE = 2'd3
	} eg_state_t;

	// attenuation, 0 is loudest and all ones is silent.
	typedef logic [`EG_LEVEL_W-1:0] eg_level_t;

	// effective rate after key scaling.
	typedef logic [`EG_RATE_W-1:0] eg_rate_t;

	// rate as written to a register.
	typedef logic [4:0] eg_raw_rate_t;

	// level increment, 0 to 8.
	typedef logic [3:0] eg_inc_t;

endpackage

`default_nettype wire

/* source/eg_rate.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module eg_rate import eg_pkg::*;
	(
	input  eg_raw_rate_t rate_i,
	input  logic [1:0] ks_i,
	input  logic [4:0] kcode_i,
	input  logic [3:0] cnt_shift_i,
	output eg_rate_t eff_rate_o,
	output logic step_o,
	output eg_inc_t inc_o
	);

	logic [1:0] ks_sh;
	logic [4:0] ks_add;
	logic [6:0] rate_sum;
	eg_rate_t eff_rate;
	logic [3:0] rate_group;
	logic [3:0] shift_need;

	// key scaling 3 adds the whole key code, key scaling 0 only its top two bits.
	assign ks_sh = 2'd3 - ks_i;
	assign ks_add = kcode_i >> ks_sh;
	assign rate_sum = {rate_i, 1'b0} + ks_add;
	assign eff_rate = rate_sum[6] ? '1 : rate_sum[5:0];

	assign rate_group = eff_rate[5:2];
	assign shift_need = 4'd11 - rate_group;

	always_comb
	begin
		step_o = 1'b0;
		inc_o = 4'd1;
		if (rate_i != '0)
		begin
			if (eff_rate < `EG_FAST_RATE)
			begin
				// slow rates step only when the counter has enough trailing zeros.
				step_o = (cnt_shift_i >= shift_need);
			end
			else
			begin
				// group 15 also fits this shift and yields 8.
				step_o = 1'b1;
				inc_o = eg_inc_t'(1) << (rate_group - 4'd12);
			end
		end
	end

	assign eff_rate_o = eff_rate;

endmodule

`default_nettype wire

/* source/eg_regs.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module eg_regs import eg_pkg::*;
	(
	input  logic mclk_i,
	input  logic rst_n_i,
	input  logic wr_i,
	input  logic [2:0] addr_i,
	input  logic [7:0] wdata_i,
	input  eg_state_t state_i,
	output eg_raw_rate_t rate_o,
	output logic [3:0] sl_o,
	output logic [6:0] tl_o,
	output logic [1:0] ks_o,
	output logic [1:0] ams_o,
	output logic [4:0] kcode_o
	);

	eg_raw_rate_t ar_q;
	eg_raw_rate_t dr_q;
	eg_raw_rate_t sr_q;
	logic [3:0] rr_q;
	logic [3:0] sl_q;
	logic [6:0] tl_q;
	logic [1:0] ks_q;
	logic [1:0] ams_q;
	logic [4:0] kc_q;

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ar_q <= '0;
			dr_q <= '0;
			sr_q <= '0;
			rr_q <= '0;
			sl_q <= '0;
			tl_q <= '0;
			ks_q <= '0;
			ams_q <= '0;
			kc_q <= '0;
		end
		else if (wr_i)
		begin
			case (addr_i)
				`EG_ADDR_AR: ar_q <= wdata_i[4:0];
				`EG_ADDR_DR: dr_q <= wdata_i[4:0];
				`EG_ADDR_SR: sr_q <= wdata_i[4:0];
				`EG_ADDR_RR: rr_q <= wdata_i[3:0];
				`EG_ADDR_SL: sl_q <= wdata_i[3:0];
				`EG_ADDR_TL: tl_q <= wdata_i[6:0];
				`EG_ADDR_KSAM:
				begin
					ks_q <= wdata_i[3:2];
					ams_q <= wdata_i[1:0];
				end
				default: kc_q <= wdata_i[4:0];
			endcase
		end
	end

	// release only has four bits, so it is doubled plus one to match the others.
	always_comb
	begin
		case (state_i)
			EG_ATTACK: rate_o = ar_q;
			EG_DECAY: rate_o = dr_q;
			EG_SUSTAIN: rate_o = sr_q;
			default: rate_o = {rr_q, 1'b1};
		endcase
	end

	assign sl_o = sl_q;
	assign tl_o = tl_q;
	assign ks_o = ks_q;
	assign ams_o = ams_q;
	assign kcode_o = kc_q;

endmodule

`default_nettype wire

/* source/eg_timer.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module eg_timer
	(
	input  logic mclk_i,
	input  logic rst_n_i,
	output logic sample_tick_o,
	output logic eg_tick_o,
	output logic [3:0] cnt_shift_o
	);

	localparam int DIV_W = $clog2(`EG_SAMPLE_DIV);
	localparam int SUB_W = $clog2(`EG_SUBCNT_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic [SUB_W-1:0] subcnt;
	logic [`EG_CNT_W-1:0] eg_cnt;
	logic [`EG_CNT_W-1:0] eg_cnt_next;
	logic tick_now;

	// index of the lowest set bit, a counter of zero gives 0.
	function automatic logic [3:0] low_bit(input logic [`EG_CNT_W-1:0] value);
		logic [3:0] idx;
		idx = '0;
		for (int i = `EG_CNT_W - 1; i >= 0; i--)
		begin
			if (value[i])
				idx = 4'(i);
		end
		return idx;
	endfunction

	assign tick_now = sample_tick_o && (subcnt == SUB_W'(`EG_SUBCNT_DIV - 1));
	assign eg_cnt_next = eg_cnt + 1'b1;

	// the sample pulse sits one clock early so the envelope tick lands on a full period.
	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			div_cnt <= '0;
			sample_tick_o <= 1'b0;
		end
		else
		begin
			sample_tick_o <= (div_cnt == DIV_W'(`EG_SAMPLE_DIV - 2));
			if (div_cnt == DIV_W'(`EG_SAMPLE_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			subcnt <= '0;
			eg_tick_o <= 1'b0;
		end
		else
		begin
			eg_tick_o <= tick_now;
			if (tick_now)
				subcnt <= '0;
			else if (sample_tick_o)
				subcnt <= subcnt + 1'b1;
		end
	end

	// the shift is taken from the new count so it is valid during the tick.
	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			eg_cnt <= '0;
			cnt_shift_o <= '0;
		end
		else if (tick_now)
		begin
			eg_cnt <= eg_cnt_next;
			cnt_shift_o <= low_bit(eg_cnt_next);
		end
	end

endmodule

`default_nettype wire

/* source/eg_top.sv */
`timescale 1ns/100ps

`default_nettype none

module eg_top import eg_pkg::*;
	(
	input  logic mclk_i,
	input  logic rst_n_i,
	input  logic wr_i,
	input  logic [2:0] addr_i,
	input  logic [7:0] wdata_i,
	input  logic kon_i,
	input  logic [5:0] lfo_am_i,
	output eg_level_t eg_out_o
	);

	eg_state_t state;
	eg_raw_rate_t rate;
	logic [3:0] sl;
	logic [6:0] tl;
	logic [1:0] ks;
	logic [1:0] ams;
	logic [4:0] kcode;
	logic eg_tick;
	logic [3:0] cnt_shift;
	eg_rate_t eff_rate;
	logic step;
	eg_inc_t inc;
	eg_level_t level;

	eg_regs u_regs
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.wr_i(wr_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.state_i(state),
		.rate_o(rate),
		.sl_o(sl),
		.tl_o(tl),
		.ks_o(ks),
		.ams_o(ams),
		.kcode_o(kcode)
		);

	// the sample pulse is only needed inside the timer.
	eg_timer u_timer
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.sample_tick_o(),
		.eg_tick_o(eg_tick),
		.cnt_shift_o(cnt_shift)
		);

	eg_rate u_rate
		(
		.rate_i(rate),
		.ks_i(ks),
		.kcode_i(kcode),
		.cnt_shift_i(cnt_shift),
		.eff_rate_o(eff_rate),
		.step_o(step),
		.inc_o(inc)
		);

	eg_envelope u_envelope
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.eg_tick_i(eg_tick),
		.kon_i(kon_i),
		.step_i(step),
		.inc_i(inc),
		.eff_rate_i(eff_rate),
		.sl_i(sl),
		.state_o(state),
		.level_o(level)
		);

	eg_output u_output
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.level_i(level),
		.tl_i(tl),
		.ams_i(ams),
		.lfo_am_i(lfo_am_i),
		.eg_out_o(eg_out_o)
		);

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/eg_pkg.sv
source/eg_regs.sv
source/eg_timer.sv
source/eg_rate.sv
source/eg_envelope.sv
source/eg_output.sv
source/eg_top.sv
testbench/tb_eg.sv

/* testbench/tb_eg.sv */
`timescale 1ns/100ps

`include "eg_defs.svh"

`default_nettype none

module tb_eg import eg_pkg::*;
	();

	localparam int TICK_CLKS = `EG_SAMPLE_DIV * `EG_SUBCNT_DIV;
	localparam int TICK_LIMIT = 4000;
	localparam int MAX_CYCLES = TICK_LIMIT * TICK_CLKS;

	logic mclk;
	logic rst_n;
	logic wr;
	logic [2:0] addr;
	logic [7:0] wdata;
	logic kon;
	logic [5:0] lfo_am;
	eg_level_t eg_out;

	int seed = 32'hc11e;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int fail_count = 0;
	int cyc = 0;
	event tick_seen;

	// model of the operator, stepped on the same edges as the DUT.
	eg_state_t m_state;
	logic [9:0] m_level;
	logic m_kon_prev;
	logic [11:0] m_cnt;
	logic [11:0] nxt_env;
	int m_out;
	int m_ar;
	int m_dr;
	int m_sr;
	int m_rr;
	int m_sl;
	int m_tl;
	int m_ks;
	int m_ams;
	int m_kc;

	eg_top DUT
		(
		.mclk_i(mclk),
		.rst_n_i(rst_n),
		.wr_i(wr),
		.addr_i(addr),
		.wdata_i(wdata),
		.kon_i(kon),
		.lfo_am_i(lfo_am),
		.eg_out_o(eg_out)
		);

	initial
	begin
		mclk = 1'b0;
		forever #20 mclk = ~mclk;
	end

	function automatic int low_set_bit(input logic [11:0] value);
		for (int i = 0; i < 12; i++)
		begin
			if (value[i])
				return i;
		end
		return 0;
	endfunction

	function automatic int eff_rate(input int raw);
		int e;
		e = 2 * raw + (m_kc >> (3 - m_ks));
		return (e > 63) ? 63 : e;
	endfunction

	// increment for one tick, zero when no step is taken.
	function automatic int step_inc(input int raw, input int shift);
		int e;
		e = eff_rate(raw);
		if (raw == 0)
			return 0;
		else if (e < `EG_FAST_RATE)
			return (shift >= 11 - e / 4) ? 1 : 0;
		else if (e < 60)
			return 1 << (e / 4 - 12);
		return 8;
	endfunction

	function automatic int state_rate(input eg_state_t st);
		case (st)
			EG_ATTACK: return m_ar;
			EG_DECAY: return m_dr;
			EG_SUSTAIN: return m_sr;
			default: return 2 * m_rr + 1;
		endcase
	endfunction

	function automatic logic [11:0] env_step(input eg_state_t st, input int lvl,
		input logic key, input logic key_prev, input int shift);
		eg_state_t ns;
		int nl;
		int inc;
		int dec;
		ns = st;
		nl = lvl;
		if (key && !key_prev)
		begin
			ns = EG_ATTACK;
			if (eff_rate(m_ar) >= `EG_INSTANT_RATE)
				nl = 0;
		end
		else if (!key && st != EG_RELEASE)
			ns = EG_RELEASE;
		else if (st == EG_ATTACK)
		begin
			inc = step_inc(m_ar, shift);
			if (inc != 0)
			begin
				dec = lvl * inc / 16 + 1;
				nl = (dec >= lvl) ? 0 : lvl - dec;
			end
			if (nl == 0)
				ns = EG_DECAY;
		end
		else if (lvl >= 1008)
			nl = 1023;
		else if (st == EG_DECAY && lvl / 32 == ((m_sl == 15) ? 31 : m_sl))
			ns = EG_SUSTAIN;
		else
		begin
			inc = step_inc(state_rate(st), shift);
			nl = (lvl + inc > 1023) ? 1023 : lvl + inc;
		end
		return {ns, nl[9:0]};
	endfunction

	function automatic int out_ref(input int lvl, input int tl, input int ams, input int lfo);
		int am;
		int sum;
		case (ams)
			0: am = 0;
			1: am = lfo / 4;
			2: am = lfo;
			default: am = lfo * 2;
		endcase
		sum = lvl + tl * 8 + am;
		return (sum > 1023) ? 1023 : sum;
	endfunction

	task automatic check_value(input string name, input int actual, input int expected);
		check_count++;
		if (actual != expected)
		begin
			$display("[ERROR] time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic write_reg(input logic [2:0] a, input int d);
		@(posedge mclk);
		wr <= 1'b1;
		addr <= a;
		wdata <= d[7:0];
		@(posedge mclk);
		wr <= 1'b0;
	endtask

	// key changes land just after a tick so the next tick sees them.
	task automatic set_key(input logic value);
		@(tick_seen);
		@(posedge mclk);
		kon <= value;
	endtask

	task automatic finish_test(input string name, input int err_start);
		test_count++;
		if (error_count == err_start)
			$display("test %0d, %s: passed", test_count, name);
		else
		begin
			fail_count++;
			$display("test %0d, %s: failed with %0d errors", test_count, name,
				error_count - err_start);
		end
	endtask

	// the envelope updates one clock after the timer tick, the output one clock later.
	always @(posedge mclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cyc = 0;
			m_state = EG_RELEASE;
			m_level = 10'd1023;
			m_kon_prev = 1'b0;
			m_cnt = '0;
			m_out = 1023;
			m_ar = 0;
			m_dr = 0;
			m_sr = 0;
			m_rr = 0;
			m_sl = 0;
			m_tl = 0;
			m_ks = 0;
			m_ams = 0;
			m_kc = 0;
		end
		else
		begin
			cyc = cyc + 1;
			m_out = out_ref(m_level, m_tl, m_ams, lfo_am);
			if (cyc > TICK_CLKS && cyc % TICK_CLKS == 1)
			begin
				m_cnt = m_cnt + 1'b1;
				nxt_env = env_step(m_state, m_level, kon, m_kon_prev, low_set_bit(m_cnt));
				m_state = eg_state_t'(nxt_env[11:10]);
				m_level = nxt_env[9:0];
				m_kon_prev = kon;
			end
			if (wr)
			begin
				case (addr)
					`EG_ADDR_AR: m_ar = wdata[4:0];
					`EG_ADDR_DR: m_dr = wdata[4:0];
					`EG_ADDR_SR: m_sr = wdata[4:0];
					`EG_ADDR_RR: m_rr = wdata[3:0];
					`EG_ADDR_SL: m_sl = wdata[3:0];
					`EG_ADDR_TL: m_tl = wdata[6:0];
					`EG_ADDR_KSAM:
					begin
						m_ks = wdata[3:2];
						m_ams = wdata[1:0];
					end
					default: m_kc = wdata[4:0];
				endcase
			end
		end
	end

	always @(negedge mclk)
	begin
		if (rst_n && cyc > TICK_CLKS && cyc % TICK_CLKS == 2)
		begin
			check_value("eg_out_o", eg_out, m_out);
			-> tick_seen;
		end
	end

	initial
	begin
		repeat (MAX_CYCLES) @(posedge mclk);
		$display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		int err_start;
		int sl_pick;
		int tl_pick;
		int ks_pick;
		int ams_pick;
		int lfo_pick;
		int prev_out;
		int loops;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		kon = 1'b0;
		lfo_am = '0;
		rst_n = 1'b0;
		repeat (8) @(posedge mclk);
		rst_n <= 1'b1;

		err_start = error_count;
		@(negedge mclk);
		check_value("eg_out_o", eg_out, 1023);
		finish_test("reset", err_start);

		err_start = error_count;
		write_reg(`EG_ADDR_AR, 31);
		write_reg(`EG_ADDR_DR, 0);
		write_reg(`EG_ADDR_SR, 0);
		set_key(1'b1);
		@(tick_seen);
		check_value("eg_out_o", eg_out, out_ref(0, 0, 0, 0));
		for (int i = 0; i < 20; i++)
		begin
			tl_pick = $random(seed) & 127;
			ks_pick = $random(seed) & 3;
			ams_pick = $random(seed) & 3;
			lfo_pick = $random(seed) & 63;
			@(posedge mclk);
			lfo_am <= 6'(lfo_pick);
			write_reg(`EG_ADDR_TL, tl_pick);
			write_reg(`EG_ADDR_KSAM, ks_pick * 4 + ams_pick);
			@(posedge mclk);
			@(negedge mclk);
			check_value("eg_out_o", eg_out, out_ref(0, tl_pick, ams_pick, lfo_pick));
		end
		finish_test("output sum", err_start);

		err_start = error_count;
		sl_pick = $random(seed) & 15;
		write_reg(`EG_ADDR_TL, 0);
		write_reg(`EG_ADDR_KSAM, 0);
		write_reg(`EG_ADDR_KC, 0);
		write_reg(`EG_ADDR_DR, 31);
		write_reg(`EG_ADDR_SL, sl_pick);
		set_key(1'b0);
		set_key(1'b1);
		loops = 0;
		while (m_state != EG_SUSTAIN && loops < 200)
		begin
			@(tick_seen);
			loops++;
		end
		if (m_state != EG_SUSTAIN)
		begin
			$display("decay did not reach the sustain state after %0d ticks", loops);
			error_count++;
		end
		@(tick_seen);
		@(tick_seen);
		check_value("eg_out_o", eg_out, out_ref(((sl_pick == 15) ? 31 : sl_pick) * 32, 0, 0, 0));
		finish_test("decay to sustain", err_start);

		err_start = error_count;
		write_reg(`EG_ADDR_RR, 15);
		set_key(1'b0);
		@(tick_seen);
		prev_out = eg_out;
		loops = 0;
		while (m_level != 10'd1023 && loops < 300)
		begin
			@(tick_seen);
			check_value("eg_out_o rising", (eg_out > prev_out) ? 1 : 0, 1);
			prev_out = eg_out;
			loops++;
		end
		if (m_level != 10'd1023)
		begin
			$display("release did not reach silence after %0d ticks", loops);
			error_count++;
		end
		check_value("eg_out_o", eg_out, 1023);
		finish_test("release", err_start);

		err_start = error_count;
		write_reg(`EG_ADDR_AR, 25);
		write_reg(`EG_ADDR_KC, 31);
		write_reg(`EG_ADDR_KSAM, 0);
		set_key(1'b1);
		@(tick_seen);
		check_value("eg_out_o", eg_out, 1023);
		prev_out = eg_out;
		loops = 0;
		while (m_state == EG_ATTACK && loops < 100)
		begin
			@(tick_seen);
			check_value("eg_out_o falling", (eg_out < prev_out) ? 1 : 0, 1);
			prev_out = eg_out;
			loops++;
		end
		if (m_state == EG_ATTACK)
		begin
			$display("attack did not finish after %0d ticks", loops);
			error_count++;
		end
		// full key scaling pushes the rate past the top, so the attack is instant.
		write_reg(`EG_ADDR_KSAM, 12);
		write_reg(`EG_ADDR_AR, 29);
		write_reg(`EG_ADDR_TL, 20);
		set_key(1'b0);
		// the instant attack has to start from silence to be seen.
		loops = 0;
		while (m_level != 10'd1023 && loops < 300)
		begin
			@(tick_seen);
			loops++;
		end
		if (m_level != 10'd1023)
		begin
			$display("release before the instant attack did not reach silence");
			error_count++;
		end
		set_key(1'b1);
		@(tick_seen);
		check_value("eg_out_o", eg_out, out_ref(0, 20, 0, 0));
		finish_test("attack and key scaling", err_start);

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_count, fail_count, check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
